//--- dv/xfer_patterns.txt
// Columns: op (1 hex digit), a (2 hex digits), b (2 hex digits).
// op 1 push a words from b, 2 pop a words expecting b on, 3 hold out_ack, 4 release,
// op 5 status used a and flags b {full,empty,afull,aempty}, 6 refused push of b, f end.
50005  // reset values
11410  // 20 words, pointers wrap
21410
50005
30000  // withhold out_ack
10340  // one word parks in the consumer
50201  // used 2, aempty high
10143
50300  // used 3, aempty low
10a44
50d00  // used 13, afull low
1014e
50e02  // used 14, afull high
1024f
5100a  // 17 words in, buffer full
60051  // 18th push gets no ack
5100a
40000  // give out_ack again
21140  // full drain, last word 0x50
50005
f0000

//--- vlog.f
+incdir+verilog
verilog/xfer_pkg.sv
verilog/dualport_ram.sv
verilog/word_fifo.sv
verilog/ingress_port.sv
verilog/egress_port.sv
verilog/xfer_top.sv
dv/tb_clkgen.sv
dv/xfer_asserts.sv
dv/xfer_tb.sv

//--- Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vxfer_tb: vlog.f verilog/*.sv verilog/*.svh dv/*.sv
	verilator --binary --timing --assert -f vlog.f --top-module xfer_tb

run: obj_dir/Vxfer_tb
	@out=$$(./obj_dir/Vxfer_tb 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module xfer_tb

clean:
	rm -rf obj_dir

//--- dv/xfer_tb.sv
`default_nettype none

module xfer_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_STEPS = 64;

  logic                 rd_clk;
  logic                 wr_rst_n;
  logic                 in_req;
  xfer_pkg::word_t      in_data;
  logic                 in_ack;
  logic                 out_req;
  xfer_pkg::word_t      out_data;
  logic                 out_ack;
  xfer_pkg::fifo_stat_t stat;

  logic [19:0]          pat [MAX_STEPS];
  xfer_pkg::word_t      rx_q [$];
  logic                 hold = 1'b0;
  logic [31:0]          lfsr_main = 32'h7239bc61;
  logic [31:0]          lfsr_cons = 32'h7239bc61;
  int                   limit = 0;
  int                   cycles = 0;

  tb_clkgen u_clkgen (.rd_clk(rd_clk));

  xfer_top DUT (
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack),
    .stat     (stat)
  );

  bind xfer_top xfer_asserts u_asserts (
    .rd_clk(rd_clk), .wr_rst_n(wr_rst_n), .in_req(in_req), .in_ack(in_ack),
    .out_req(out_req), .out_data(out_data), .stat(stat), .wr(wr)
  );

  // Galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at first error.");
  endtask

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
      abort_run("A checked value was wrong.");
    end
  endtask

  // Two LFSR bits give a pause of 0 to 3 cycles.
  task automatic random_wait(inout logic [31:0] st);
    logic [1:0] n;
    n = '0;
    repeat (2) begin
      n  = {n[0], st[0]};
      st = lfsr_step(st);
    end
    repeat (n) @(negedge rd_clk);
  endtask

  task automatic push_word(input xfer_pkg::word_t w);
    random_wait(lfsr_main);
    in_data = w;
    in_req  = 1'b1;
    @(negedge rd_clk);
    while (!in_ack) @(negedge rd_clk);
    random_wait(lfsr_main);
    in_req = 1'b0;
    @(negedge rd_clk);
    while (in_ack) @(negedge rd_clk);
  endtask

  task automatic refused_push(input string name, input xfer_pkg::word_t w);
    in_data = w;
    in_req  = 1'b1;
    repeat (20) begin
      @(negedge rd_clk);
      compare_values({name, " refused ack"}, 32'd0, 32'(in_ack));
    end
    in_req = 1'b0;
    @(negedge rd_clk);
  endtask

  task automatic pop_check(input string name, input xfer_pkg::word_t expected);
    xfer_pkg::word_t got;
    while (rx_q.size() == 0) @(negedge rd_clk);
    got = rx_q.pop_front();
    compare_values({name, " pop"}, 32'(expected), 32'(got));
  endtask

  // Flags are {full, empty, afull, aempty}.
  task automatic check_status(input string name, input logic [7:0] used,
                              input logic [3:0] flags);
    int quiet;
    quiet = 0;
    while (quiet < 4) begin
      @(negedge rd_clk);
      if (!in_req && !in_ack && !out_ack && (!out_req || hold)) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    compare_values({name, " used"}, 32'(used), 32'(stat.used));
    compare_values({name, " flags"}, 32'(flags),
                   32'({stat.full, stat.empty, stat.afull, stat.aempty}));
  endtask

  initial begin
    int              idx;
    int              n_steps;
    logic [3:0]      op;
    logic [7:0]      a;
    xfer_pkg::word_t w;
    string           name;
    wr_rst_n = 1'b0;
    in_req   = 1'b0;
    in_data  = '0;
    $readmemh("dv/xfer_patterns.txt", pat);
    n_steps = 0;
    while (n_steps < MAX_STEPS && pat[n_steps][19:16] != 4'hf) begin
      n_steps++;
    end
    if (n_steps == MAX_STEPS) begin
      abort_run("The pattern file has no end marker.");
    end
    limit = 200 * n_steps;
    repeat (16) @(negedge rd_clk);
    wr_rst_n = 1'b1;
    for (idx = 0; idx < n_steps; idx++) begin
      op   = pat[idx][19:16];
      a    = pat[idx][15:8];
      w    = pat[idx][7:0];
      name = $sformatf("step %0d", idx + 1);
      case (op)
        4'h1: begin
          repeat (a) begin
            push_word(w);
            w++;
          end
        end
        4'h2: begin
          repeat (a) begin
            pop_check(name, w);
            w++;
          end
        end
        4'h3: hold = 1'b1;
        4'h4: hold = 1'b0;
        4'h5: check_status(name, a, w[3:0]);
        4'h6: refused_push(name, w);
        default: abort_run($sformatf("Unknown operation %0h in %s.", op, name));
      endcase
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  // Output host, records each word when it acknowledges it.
  initial begin
    out_ack = 1'b0;
    forever begin
      @(negedge rd_clk);
      if (out_req && !hold) begin
        random_wait(lfsr_cons);
        rx_q.push_back(out_data);
        out_ack = 1'b1;
        @(negedge rd_clk);
        while (out_req) @(negedge rd_clk);
        random_wait(lfsr_cons);
        out_ack = 1'b0;
      end
    end
  end

  always @(posedge rd_clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles.", limit));
    end
  end

  always @(negedge rd_clk) begin
    if (DUT.u_asserts.fired) begin
      abort_run("A protocol assertion on the DUT failed.");
    end
  end

endmodule

`default_nettype wire

//--- dv/xfer_asserts.sv
`default_nettype none
`include "xfer_cfg.svh"

module xfer_asserts (
  input wire                        rd_clk,
  input wire                        wr_rst_n,
  input wire                        in_req,
  input wire                        in_ack,
  input wire                        out_req,
  input wire xfer_pkg::word_t       out_data,
  input wire xfer_pkg::fifo_stat_t  stat,
  input wire xfer_pkg::fifo_wr_t    wr
);
  timeunit 1ns;
  timeprecision 100ps;

  // Sticky flag that the testbench top polls.
  logic fired = 1'b0;

  // Ack rises the cycle after the write, so req was high one cycle earlier.
  a_ack_needs_req: assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    $rose(in_ack) |-> $past(in_req))
    else begin
      $error("in_ack rose while in_req was low");
      fired = 1'b1;
    end

  a_out_data_stable: assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    (out_req && $past(out_req)) |-> $stable(out_data))
    else begin
      $error("out_data changed during out_req");
      fired = 1'b1;
    end

  a_full_empty: assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    !(stat.full && stat.empty))
    else begin
      $error("full and empty both high");
      fired = 1'b1;
    end

  a_no_write_full: assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    wr.en |-> (stat.used != xfer_pkg::count_t'(`XFER_DEPTH)))
    else begin
      $error("write issued while the buffer held a full load");
      fired = 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
`default_nettype none

module tb_clkgen (
  output logic rd_clk
);
  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period.
  initial begin
    rd_clk = 1'b0;
    forever #4 rd_clk = ~rd_clk;
  end

endmodule

`default_nettype wire

//--- verilog/xfer_top.sv
`default_nettype none

module xfer_top (
  input  wire                    rd_clk,
  input  wire                    wr_rst_n,
  input  wire                    in_req,
  input  wire xfer_pkg::word_t   in_data,
  output logic                   in_ack,
  output logic                   out_req,
  output xfer_pkg::word_t        out_data,
  input  wire                    out_ack,
  output xfer_pkg::fifo_stat_t   stat
);

  xfer_pkg::fifo_wr_t wr;
  logic               rd_en;
  xfer_pkg::word_t    rd_data;

  ingress_port u_ingress (
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .stat     (stat),
    .wr       (wr)
  );

  word_fifo u_fifo (
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .wr       (wr),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .stat     (stat)
  );

  egress_port u_egress (
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .stat     (stat),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack)
  );

endmodule

`default_nettype wire

//--- verilog/egress_port.sv
`default_nettype none

module egress_port (
  input  wire                        rd_clk,
  input  wire                        wr_rst_n,
  input  wire xfer_pkg::fifo_stat_t  stat,
  output logic                       rd_en,
  input  wire xfer_pkg::word_t       rd_data,
  output logic                       out_req,
  output xfer_pkg::word_t            out_data,
  input  wire                        out_ack
);

  xfer_pkg::egress_state_t state_q;
  xfer_pkg::egress_state_t state_nxt;

  // Pop as soon as a word is there and nothing is held.
  assign rd_en = (state_q == xfer_pkg::EG_IDLE) && !stat.empty;

  assign out_req = (state_q == xfer_pkg::EG_OFFER);

  always_comb begin
    state_nxt = state_q;
    unique case (state_q)
      xfer_pkg::EG_IDLE: begin
        if (!stat.empty) begin
          state_nxt = xfer_pkg::EG_FETCH;
        end
      end
      xfer_pkg::EG_FETCH: begin
        state_nxt = xfer_pkg::EG_OFFER;
      end
      xfer_pkg::EG_OFFER: begin
        if (out_ack) begin
          state_nxt = xfer_pkg::EG_WAIT_REL;
        end
      end
      xfer_pkg::EG_WAIT_REL: begin
        if (!out_ack) begin
          state_nxt = xfer_pkg::EG_IDLE;
        end
      end
      default: begin
        state_nxt = xfer_pkg::EG_IDLE;
      end
    endcase
  end

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      state_q <= xfer_pkg::EG_IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  // RAM output is valid in the fetch cycle; hold it for the whole offer.
  always_ff @(posedge rd_clk) begin
    if (state_q == xfer_pkg::EG_FETCH) begin
      out_data <= rd_data;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ingress_port.sv
`default_nettype none

module ingress_port (
  input  wire                        rd_clk,
  input  wire                        wr_rst_n,
  input  wire                        in_req,
  input  wire xfer_pkg::word_t       in_data,
  output logic                       in_ack,
  input  wire xfer_pkg::fifo_stat_t  stat,
  output xfer_pkg::fifo_wr_t         wr
);

  xfer_pkg::ingress_state_t state_q;
  xfer_pkg::ingress_state_t state_nxt;
  logic                     take;

  // Accept the word only while idle and the buffer has room.
  assign take = (state_q == xfer_pkg::IN_IDLE) && in_req && !stat.full;

  assign wr.en   = take;
  assign wr.data = in_data;

  // Ack is high from the cycle after the write until release is seen.
  assign in_ack = (state_q != xfer_pkg::IN_IDLE);

  always_comb begin
    state_nxt = state_q;
    unique case (state_q)
      xfer_pkg::IN_IDLE: begin
        if (take) begin
          state_nxt = xfer_pkg::IN_ACK;
        end
      end
      xfer_pkg::IN_ACK: begin
        if (!in_req) begin
          state_nxt = xfer_pkg::IN_IDLE;
        end else begin
          state_nxt = xfer_pkg::IN_WAIT_REL;
        end
      end
      xfer_pkg::IN_WAIT_REL: begin
        if (!in_req) begin
          state_nxt = xfer_pkg::IN_IDLE;
        end
      end
      default: begin
        state_nxt = xfer_pkg::IN_IDLE;
      end
    endcase
  end

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      state_q <= xfer_pkg::IN_IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

endmodule

`default_nettype wire

//--- verilog/word_fifo.sv
`default_nettype none
`include "xfer_cfg.svh"

module word_fifo (
  input  wire                      rd_clk,
  input  wire                      wr_rst_n,
  input  wire xfer_pkg::fifo_wr_t  wr,
  input  wire                      rd_en,
  output xfer_pkg::word_t          rd_data,
  output xfer_pkg::fifo_stat_t     stat
);

  localparam int MSB = `XFER_ADDR_W;

  localparam xfer_pkg::count_t AFULL_LVL  = xfer_pkg::count_t'(`XFER_AFULL);
  localparam xfer_pkg::count_t AEMPTY_LVL = xfer_pkg::count_t'(`XFER_AEMPTY);

  xfer_pkg::ptr_t   wr_ptr_q;
  xfer_pkg::ptr_t   rd_ptr_q;
  xfer_pkg::ptr_t   wr_ptr_nxt;
  xfer_pkg::ptr_t   rd_ptr_nxt;
  xfer_pkg::count_t used_nxt;
  logic             full_nxt;
  logic             empty_nxt;

  dualport_ram u_ram (
    .rd_clk  (rd_clk),
    .wr_en   (wr.en),
    .wr_addr (xfer_pkg::addr_t'(wr_ptr_q[MSB-1:0])),
    .wr_data (wr.data),
    .rd_en   (rd_en),
    .rd_addr (xfer_pkg::addr_t'(rd_ptr_q[MSB-1:0])),
    .rd_data (rd_data)
  );

  // The producer only writes when full is low.
  always_comb begin
    if (wr.en) begin
      wr_ptr_nxt = wr_ptr_q + xfer_pkg::ptr_t'(1);
    end else begin
      wr_ptr_nxt = wr_ptr_q;
    end
  end

  always_comb begin
    if (rd_en) begin
      rd_ptr_nxt = rd_ptr_q + xfer_pkg::ptr_t'(1);
    end else begin
      rd_ptr_nxt = rd_ptr_q;
    end
  end

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_nxt;
      rd_ptr_q <= rd_ptr_nxt;
    end
  end

  // Modulo difference of the wide pointers gives 0 to DEPTH.
  assign used_nxt = xfer_pkg::count_t'(wr_ptr_nxt - rd_ptr_nxt);

  // Same address with wrap bits differing means a full lap ahead.
  assign full_nxt  = (wr_ptr_nxt[MSB] != rd_ptr_nxt[MSB]) &&
                     (wr_ptr_nxt[MSB-1:0] == rd_ptr_nxt[MSB-1:0]);
  assign empty_nxt = (wr_ptr_nxt == rd_ptr_nxt);

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      stat.full   <= 1'b0;
      stat.empty  <= 1'b1;
      stat.afull  <= 1'b0;
      stat.aempty <= 1'b1;
      stat.used   <= '0;
    end else begin
      stat.full   <= full_nxt;
      stat.empty  <= empty_nxt;
      stat.afull  <= (used_nxt >= AFULL_LVL);
      stat.aempty <= (used_nxt <= AEMPTY_LVL);
      stat.used   <= used_nxt;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dualport_ram.sv
`default_nettype none

module dualport_ram (
  input  wire                   rd_clk,
  input  wire                   wr_en,
  input  wire xfer_pkg::addr_t  wr_addr,
  input  wire xfer_pkg::word_t  wr_data,
  input  wire                   rd_en,
  input  wire xfer_pkg::addr_t  rd_addr,
  output xfer_pkg::word_t       rd_data
);

  localparam int DEPTH = 1 << $bits(xfer_pkg::addr_t);

  xfer_pkg::word_t mem [DEPTH];

  // Write port.
  always_ff @(posedge rd_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port, data appears the cycle after rd_en.
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- verilog/xfer_pkg.sv
`default_nettype none
`include "xfer_cfg.svh"

package xfer_pkg;

  typedef logic [`XFER_WORD_W-1:0] word_t;
  typedef logic [`XFER_ADDR_W-1:0] addr_t;

  // Top bit is the wrap bit.
  typedef logic [`XFER_ADDR_W:0] ptr_t;
  typedef logic [`XFER_ADDR_W:0] count_t;

  typedef struct packed {
    logic  en;
    word_t data;
  } fifo_wr_t;

  typedef struct packed {
    logic   full;
    logic   empty;
    logic   afull;
    logic   aempty;
    count_t used;
  } fifo_stat_t;

  typedef enum logic [1:0] {IN_IDLE, IN_ACK, IN_WAIT_REL} ingress_state_t;

  typedef enum logic [1:0] {EG_IDLE, EG_FETCH, EG_OFFER, EG_WAIT_REL} egress_state_t;

endpackage

`default_nettype wire

//--- verilog/xfer_cfg.svh
`ifndef XFER_CFG_SVH
`define XFER_CFG_SVH

// Width of one data word.
`define XFER_WORD_W 8

// Buffer entries. Must be a power of two.
`define XFER_DEPTH 16

// RAM address width, log2 of the depth.
`define XFER_ADDR_W 4

// Almost-full is raised at this occupancy and above.
`define XFER_AFULL 14

// Almost-empty is raised at this occupancy and below.
`define XFER_AEMPTY 2

`endif
